/* logic/cfg_addr_pkg.sv */
`default_nettype none

package cfg_addr_pkg;

    // Control and interrupt block
    localparam logic [12:0] CONTROL_OFFSET     = 13'h000;
    localparam logic [12:0] INTR_EN_OFFSET     = 13'h004;
    localparam logic [12:0] INTR_STATUS_OFFSET = 13'h00C;

    // Argument region bases
    localparam logic [12:0] MAIN_BASE = 13'h200;
    localparam logic [12:0] ACT_BASE  = 13'h400;
    localparam logic [12:0] WEI_BASE  = 13'h600;
    localparam logic [12:0] OUT_BASE  = 13'h800;

    // Words per region, consecutive words are four bytes apart
    localparam int MAIN_WORDS = 2;
    localparam int ACT_WORDS  = 9;
    localparam int WEI_WORDS  = 4;
    localparam int OUT_WORDS  = 5;
    localparam int INTR_WORDS = 2;

    // Whole burst including the interrupt enables
    localparam int CFG_WRITES = MAIN_WORDS + ACT_WORDS + WEI_WORDS + OUT_WORDS + INTR_WORDS;

endpackage

`default_nettype wire

/* logic/seq_pkg.sv */
`default_nettype none

package seq_pkg;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_SEND_CFG,
        ST_DRAIN_CFG,
        ST_SEND_START,
        ST_DRAIN_START,
        ST_WAIT_IRQ,
        ST_SEND_CLEAR,
        ST_DRAIN_CLEAR,
        ST_FINISH
    } seq_state_t;

    typedef enum logic [2:0] {
        REG_MAIN,
        REG_ACT,
        REG_WEI,
        REG_OUT,
        REG_INTR
    } cfg_region_t;

    typedef enum logic [1:0] {
        WK_CFG,
        WK_START,
        WK_CLEAR
    } write_kind_t;

endpackage

`default_nettype wire

/* logic/seq_fsm.sv */
`default_nettype none

module seq_fsm
    import seq_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        no_start,
    input  logic        accel_irq,
    input  logic        dma_rd_irq,
    input  logic        dma_wr_irq,
    input  logic        drained,
    input  logic        burst_done,
    output logic        write_req,
    output write_kind_t write_kind,
    output logic        done,
    output logic        fwd_accel_irq,
    output logic        fwd_dma_rd_irq,
    output logic        fwd_dma_wr_irq
);

    seq_state_t state;
    logic       no_start_q;
    logic       all_clear;

    // Generator idle and every response returned
    assign all_clear = drained && burst_done;

    // Interrupts only pass through while no sequence runs
    assign fwd_accel_irq  = (state == ST_IDLE) && accel_irq;
    assign fwd_dma_rd_irq = (state == ST_IDLE) && dma_rd_irq;
    assign fwd_dma_wr_irq = (state == ST_IDLE) && dma_wr_irq;

    assign done = (state == ST_FINISH);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            write_req  <= 1'b0;
            write_kind <= WK_CFG;
            no_start_q <= 1'b0;
        end else begin
            write_req <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        no_start_q <= no_start;
                        write_req  <= 1'b1;
                        write_kind <= WK_CFG;
                        state      <= ST_SEND_CFG;
                    end
                end
                // Request cycle only, the generator takes over
                ST_SEND_CFG: begin
                    state <= ST_DRAIN_CFG;
                end
                ST_DRAIN_CFG: begin
                    if (all_clear) begin
                        write_req  <= 1'b1;
                        write_kind <= WK_START;
                        state      <= ST_SEND_START;
                    end
                end
                ST_SEND_START: begin
                    state <= ST_DRAIN_START;
                end
                ST_DRAIN_START: begin
                    if (all_clear) begin
                        state <= no_start_q ? ST_FINISH : ST_WAIT_IRQ;
                    end
                end
                ST_WAIT_IRQ: begin
                    if (accel_irq) begin
                        write_req  <= 1'b1;
                        write_kind <= WK_CLEAR;
                        state      <= ST_SEND_CLEAR;
                    end
                end
                ST_SEND_CLEAR: begin
                    state <= ST_DRAIN_CLEAR;
                end
                ST_DRAIN_CLEAR: begin
                    if (all_clear) begin
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/wresp_tracker.sv */
`default_nettype none

module wresp_tracker
    import cfg_addr_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic write_issued,
    input  logic bvalid,
    output logic bready,
    output logic drained
);

    // Wide enough for a full burst in flight
    localparam int CNT_W = $clog2(CFG_WRITES + 1);

    logic [CNT_W-1:0] outstanding;
    logic             resp_taken;

    assign resp_taken = bvalid && bready;

    assign bready  = (outstanding != '0);
    assign drained = (outstanding == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= '0;
        end else begin
            case ({write_issued, resp_taken})
                2'b10: begin
                    outstanding <= outstanding + 1'b1;
                end
                2'b01: begin
                    outstanding <= outstanding - 1'b1;
                end
                // Both or neither leave the count unchanged
                default: begin
                    outstanding <= outstanding;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/cfg_write_gen.sv */
`default_nettype none

module cfg_write_gen
    import cfg_addr_pkg::*;
    import seq_pkg::*;
#(
    parameter int N_ARGS = 20,
    parameter int ADDR_W = 13
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   write_req,
    input  write_kind_t            write_kind,
    input  logic                   keep_a,
    input  logic                   keep_b,
    input  logic                   keep_c,
    input  logic                   no_start,
    input  logic [N_ARGS-1:0][31:0] args,
    input  logic                   awready,
    input  logic                   wready,
    output logic                   awvalid,
    output logic [31:0]            awaddr,
    output logic                   wvalid,
    output logic [31:0]            wdata,
    output logic                   write_issued,
    output logic                   burst_done
);

    localparam int IDX_W = $clog2(N_ARGS + 1);

    logic              busy;
    write_kind_t       kind_q;
    cfg_region_t       region;
    logic [ADDR_W-1:0] addr;
    logic [3:0]        words_left;
    logic [IDX_W-1:0]  arg_idx;
    logic              aw_done;
    logic              w_done;
    logic              keep_a_q;
    logic              keep_b_q;
    logic              keep_c_q;
    logic              no_start_q;
    logic              aw_fire;
    logic              w_fire;
    logic [31:0]       start_word;

    assign awvalid = busy && !aw_done;
    assign wvalid  = busy && !w_done;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    // Both halves in, possibly in different cycles
    assign write_issued = busy && (aw_done || aw_fire) && (w_done || w_fire);
    assign burst_done   = !busy;

    assign awaddr = {{(32 - ADDR_W){1'b0}}, addr};

    always_comb begin
        start_word     = '0;
        start_word[0]  = !no_start_q;
        start_word[1]  = 1'b1;
        start_word[16] = 1'b1;
        start_word[17] = keep_a_q;
        start_word[18] = keep_b_q;
        start_word[19] = keep_c_q;
    end

    always_comb begin
        case (kind_q)
            WK_CFG:   wdata = (region == REG_INTR) ? 32'd1 : args[arg_idx];
            WK_START: wdata = start_word;
            default:  wdata = 32'd1;
        endcase
    end

    // Mode bits are taken once per sequence
    always_ff @(posedge clk) begin
        if (write_req && write_kind == WK_CFG) begin
            keep_a_q   <= keep_a;
            keep_b_q   <= keep_b;
            keep_c_q   <= keep_c;
            no_start_q <= no_start;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            kind_q  <= WK_CFG;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else if (write_req) begin
            busy       <= 1'b1;
            kind_q     <= write_kind;
            aw_done    <= 1'b0;
            w_done     <= 1'b0;
            region     <= REG_MAIN;
            words_left <= 4'(MAIN_WORDS - 1);
            arg_idx    <= '0;
            case (write_kind)
                WK_CFG:   addr <= ADDR_W'(MAIN_BASE);
                WK_START: addr <= ADDR_W'(CONTROL_OFFSET);
                default:  addr <= ADDR_W'(INTR_STATUS_OFFSET);
            endcase
        end else if (write_issued) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            if (kind_q != WK_CFG) begin
                busy <= 1'b0;
            end else if (words_left != 4'd0) begin
                addr       <= addr + ADDR_W'(4);
                words_left <= words_left - 4'd1;
                if (region != REG_INTR) begin
                    arg_idx <= arg_idx + 1'b1;
                end
            end else begin
                if (region != REG_INTR) begin
                    arg_idx <= arg_idx + 1'b1;
                end
                // Step to the next region
                case (region)
                    REG_MAIN: begin
                        region     <= REG_ACT;
                        addr       <= ADDR_W'(ACT_BASE);
                        words_left <= 4'(ACT_WORDS - 1);
                    end
                    REG_ACT: begin
                        region     <= REG_WEI;
                        addr       <= ADDR_W'(WEI_BASE);
                        words_left <= 4'(WEI_WORDS - 1);
                    end
                    REG_WEI: begin
                        region     <= REG_OUT;
                        addr       <= ADDR_W'(OUT_BASE);
                        words_left <= 4'(OUT_WORDS - 1);
                    end
                    REG_OUT: begin
                        region     <= REG_INTR;
                        addr       <= ADDR_W'(INTR_EN_OFFSET);
                        words_left <= 4'(INTR_WORDS - 1);
                    end
                    default: begin
                        busy <= 1'b0;
                    end
                endcase
            end
        end else begin
            if (aw_fire) begin
                aw_done <= 1'b1;
            end
            if (w_fire) begin
                w_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/accel_cfg_sequencer.sv */
`default_nettype none

module accel_cfg_sequencer
    import seq_pkg::*;
#(
    parameter int N_ARGS = 20,
    parameter int ADDR_W = 13
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    output logic                    done,
    input  logic [N_ARGS-1:0][31:0] args,
    input  logic                    keep_a,
    input  logic                    keep_b,
    input  logic                    keep_c,
    input  logic                    no_start,
    input  logic                    accel_irq,
    input  logic                    dma_rd_irq,
    input  logic                    dma_wr_irq,
    output logic                    fwd_accel_irq,
    output logic                    fwd_dma_rd_irq,
    output logic                    fwd_dma_wr_irq,
    output logic                    awvalid,
    input  logic                    awready,
    output logic [31:0]             awaddr,
    output logic                    wvalid,
    input  logic                    wready,
    output logic [31:0]             wdata,
    input  logic                    bvalid,
    output logic                    bready
);

    logic        write_req;
    write_kind_t write_kind;
    logic        write_issued;
    logic        burst_done;
    logic        drained;

    seq_fsm i_fsm (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .no_start       (no_start),
        .accel_irq      (accel_irq),
        .dma_rd_irq     (dma_rd_irq),
        .dma_wr_irq     (dma_wr_irq),
        .drained        (drained),
        .burst_done     (burst_done),
        .write_req      (write_req),
        .write_kind     (write_kind),
        .done           (done),
        .fwd_accel_irq  (fwd_accel_irq),
        .fwd_dma_rd_irq (fwd_dma_rd_irq),
        .fwd_dma_wr_irq (fwd_dma_wr_irq)
    );

    wresp_tracker i_tracker (
        .clk          (clk),
        .rst          (rst),
        .write_issued (write_issued),
        .bvalid       (bvalid),
        .bready       (bready),
        .drained      (drained)
    );

    cfg_write_gen #(
        .N_ARGS (N_ARGS),
        .ADDR_W (ADDR_W)
    ) i_gen (
        .clk          (clk),
        .rst          (rst),
        .write_req    (write_req),
        .write_kind   (write_kind),
        .keep_a       (keep_a),
        .keep_b       (keep_b),
        .keep_c       (keep_c),
        .no_start     (no_start),
        .args         (args),
        .awready      (awready),
        .wready       (wready),
        .awvalid      (awvalid),
        .awaddr       (awaddr),
        .wvalid       (wvalid),
        .wdata        (wdata),
        .write_issued (write_issued),
        .burst_done   (burst_done)
    );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Free running, half period per phase
    always begin
        #(PERIOD / 2);
        clk = ~clk;
    end

endmodule

`default_nettype wire

/* tb/seq_assertions.sv */
`default_nettype none

module seq_assertions (
    input logic        clk,
    input logic        rst,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] awaddr,
    input logic        wvalid,
    input logic        wready,
    input logic [31:0] wdata,
    input logic        done
);

    // Address half stays put until taken
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid or awaddr changed before awready");

    // Same for the data half
    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("wvalid or wdata changed before wready");

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

endmodule

`default_nettype wire

/* tb/tb_top.sv */
`default_nettype none

module tb_top
    import cfg_addr_pkg::*;
();

    localparam int N_ARGS          = 20;
    localparam int ADDR_W          = 13;
    localparam int RESET_CYCLES    = 5;
    localparam int MAX_TESTS       = 32;
    localparam int WORDS_PER_TEST  = N_ARGS + 2;
    localparam int CYCLES_PER_TEST = 400;

    logic                    clk;
    logic                    rst        = 1'b1;
    logic                    start      = 1'b0;
    logic [N_ARGS-1:0][31:0] args       = '0;
    logic                    keep_a     = 1'b0;
    logic                    keep_b     = 1'b0;
    logic                    keep_c     = 1'b0;
    logic                    no_start   = 1'b0;
    logic                    accel_irq  = 1'b0;
    logic                    dma_rd_irq = 1'b0;
    logic                    dma_wr_irq = 1'b0;
    logic                    awready    = 1'b0;
    logic                    wready     = 1'b0;
    logic                    bvalid     = 1'b0;
    logic                    done;
    logic                    fwd_accel_irq;
    logic                    fwd_dma_rd_irq;
    logic                    fwd_dma_wr_irq;
    logic                    awvalid;
    logic                    wvalid;
    logic                    bready;
    logic [31:0]             awaddr;
    logic [31:0]             wdata;

    logic [31:0] test_mem [0:MAX_TESTS*WORDS_PER_TEST];
    int          num_tests     = 0;
    int          timeout_limit = 0;
    int          cycle_count   = 0;
    int          done_count    = 0;
    int          write_cnt     = 0;
    int          resp_cnt      = 0;
    logic [31:0] lfsr_state    = 32'h730e_1bbb;
    logic        aw_held       = 1'b0;
    logic        w_held        = 1'b0;
    logic [31:0] aw_addr_q     = '0;
    logic [31:0] w_data_q      = '0;
    logic [1:0]  resp_q[$];

    tb_clock #(.PERIOD(100)) i_clock (.clk(clk));

    accel_cfg_sequencer #(
        .N_ARGS (N_ARGS),
        .ADDR_W (ADDR_W)
    ) i_dut (
        .clk(clk), .rst(rst), .start(start), .done(done), .args(args),
        .keep_a(keep_a), .keep_b(keep_b), .keep_c(keep_c), .no_start(no_start),
        .accel_irq(accel_irq), .dma_rd_irq(dma_rd_irq), .dma_wr_irq(dma_wr_irq),
        .fwd_accel_irq(fwd_accel_irq), .fwd_dma_rd_irq(fwd_dma_rd_irq),
        .fwd_dma_wr_irq(fwd_dma_wr_irq),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready)
    );

    bind accel_cfg_sequencer seq_assertions i_seq_assertions (
        .clk(clk), .rst(rst), .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .done(done)
    );

    task automatic abort_run(input string reason);
        if (reason != "") begin
            $display("%s", reason);
        end
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run("");
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[31]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Regions in order with four bytes per word
    function automatic logic [31:0] burst_addr(input int k);
        logic [31:0] a;
        if (k < MAIN_WORDS) begin
            a = 32'(MAIN_BASE) + 32'(4 * k);
        end else if (k < MAIN_WORDS + ACT_WORDS) begin
            a = 32'(ACT_BASE) + 32'(4 * (k - MAIN_WORDS));
        end else if (k < MAIN_WORDS + ACT_WORDS + WEI_WORDS) begin
            a = 32'(WEI_BASE) + 32'(4 * (k - MAIN_WORDS - ACT_WORDS));
        end else if (k < N_ARGS) begin
            a = 32'(OUT_BASE) + 32'(4 * (k - MAIN_WORDS - ACT_WORDS - WEI_WORDS));
        end else begin
            a = 32'(INTR_EN_OFFSET) + 32'(4 * (k - N_ARGS));
        end
        return a;
    endfunction

    task automatic check_write(input int k, input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] start_exp;
        start_exp     = 32'h0001_0002;
        start_exp[0]  = !no_start;
        start_exp[17] = keep_a;
        start_exp[18] = keep_b;
        start_exp[19] = keep_c;
        if (k < CFG_WRITES) begin
            check_value($sformatf("awaddr of burst write %0d", k), addr, burst_addr(k));
            check_value($sformatf("wdata of burst write %0d", k), data,
                        (k < N_ARGS) ? args[k] : 32'd1);
        end else if (k == CFG_WRITES) begin
            check_value("bvalid count before start write", 32'(resp_cnt), 32'(CFG_WRITES));
            check_value("awaddr of start write", addr, 32'(CONTROL_OFFSET));
            check_value("wdata of start write", data, start_exp);
        end else if (k == CFG_WRITES + 1) begin
            check_value("no_start at clear write", 32'(no_start), 32'd0);
            check_value("accel_irq at clear write", 32'(accel_irq), 32'd1);
            check_value("awaddr of clear write", addr, 32'(INTR_STATUS_OFFSET));
            check_value("wdata of clear write", data, 32'd1);
        end else begin
            abort_run($sformatf("Unexpected write %0d to address 0x%08h", k, addr));
        end
    endtask

    // AXI write slave with random ready and response delays
    always @(posedge clk) begin
        logic [31:0] r;
        logic        got_aw;
        logic        got_w;
        logic [31:0] addr_v;
        logic [31:0] data_v;
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            aw_held = 1'b0;
            w_held  = 1'b0;
            resp_q.delete();
        end else begin
            // Responses still owed by the slave
            check_value("bready", 32'(bready), 32'(resp_q.size() != 0));
            draw_bits(1, r);
            awready <= r[0];
            draw_bits(1, r);
            wready <= r[0];
            got_aw = aw_held || (awvalid && awready);
            got_w  = w_held || (wvalid && wready);
            addr_v = aw_held ? aw_addr_q : awaddr;
            data_v = w_held ? w_data_q : wdata;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                void'(resp_q.pop_front());
                resp_cnt <= resp_cnt + 1;
            end else if (!bvalid && resp_q.size() != 0) begin
                if (resp_q[0] == 2'd0) begin
                    bvalid <= 1'b1;
                end else begin
                    resp_q[0] = resp_q[0] - 2'd1;
                end
            end
            if (got_aw && got_w) begin
                check_write(write_cnt, addr_v, data_v);
                write_cnt <= write_cnt + 1;
                draw_bits(2, r);
                resp_q.push_back(r[1:0]);
                aw_held = 1'b0;
                w_held  = 1'b0;
            end else begin
                aw_held   = got_aw;
                w_held    = got_w;
                aw_addr_q = addr_v;
                w_data_q  = data_v;
            end
            if (start) begin
                write_cnt <= 0;
                resp_cnt  <= 0;
            end
        end
    end

    // Every done pulse of the run
    always @(posedge clk) begin
        if (!rst && done) begin
            done_count <= done_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            abort_run($sformatf("Timeout after %0d cycles, tests did not finish", cycle_count));
        end
    end

    task automatic run_test(input int t);
        int         base;
        int         i;
        int         irq_delay;
        int         irq_wait;
        int         exp_writes;
        logic [3:0] mode;
        logic [2:0] pat;
        logic       irq_raised;
        base       = 1 + t * WORDS_PER_TEST;
        mode       = test_mem[base][3:0];
        irq_delay  = int'(test_mem[base + 1]);
        exp_writes = mode[0] ? CFG_WRITES + 1 : CFG_WRITES + 2;
        pat        = 3'd0;
        // Walk all interrupt patterns while idle
        for (i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i != 0) begin
                check_value("fwd irqs while idle",
                            32'({fwd_accel_irq, fwd_dma_rd_irq, fwd_dma_wr_irq}), 32'(pat));
            end
            pat = 3'(i);
            {accel_irq, dma_rd_irq, dma_wr_irq} <= pat;
        end
        @(posedge clk);
        check_value("fwd irqs while idle",
                    32'({fwd_accel_irq, fwd_dma_rd_irq, fwd_dma_wr_irq}), 32'(pat));
        for (i = 0; i < N_ARGS; i++) begin
            args[i] <= test_mem[base + 2 + i];
        end
        no_start <= mode[0];
        keep_a   <= mode[1];
        keep_b   <= mode[2];
        keep_c   <= mode[3];
        // No-start runs hold accel_irq high to show that it is ignored
        accel_irq  <= mode[0];
        dma_rd_irq <= 1'b1;
        dma_wr_irq <= 1'b1;
        start      <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        irq_raised = 1'b0;
        irq_wait   = 0;
        do begin
            @(posedge clk);
            check_value("fwd irqs while busy",
                        32'({fwd_accel_irq, fwd_dma_rd_irq, fwd_dma_wr_irq}), 32'd0);
            if (!mode[0] && !irq_raised && resp_cnt == CFG_WRITES + 1) begin
                if (irq_wait == irq_delay) begin
                    accel_irq  <= 1'b1;
                    irq_raised = 1'b1;
                end else begin
                    irq_wait++;
                end
            end
            if (irq_raised && write_cnt == CFG_WRITES + 2) begin
                accel_irq <= 1'b0;
            end
        end while (!done);
        check_value("awvalid write count at done", 32'(write_cnt), 32'(exp_writes));
        check_value("bvalid count at done", 32'(resp_cnt), 32'(exp_writes));
    endtask

    initial begin
        int t;
        $readmemh("tb/seq_tests.txt", test_mem);
        num_tests = int'(test_mem[0]);
        if (num_tests < 1 || num_tests > MAX_TESTS) begin
            abort_run("Test file tb/seq_tests.txt holds no valid test count");
        end
        timeout_limit = num_tests * CYCLES_PER_TEST + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        @(posedge clk);
        if (done_count != num_tests) begin
            abort_run("Number of done pulses differs from the number of tests");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb/seq_tests.txt */
// Word 0 is the test count; each test is mode, irq delay, then twenty argument words
// Mode bits: 0 no_start, 1 keep_a, 2 keep_b, 3 keep_c; irq delay in cycles
00000006
// Test 1: run mode, no keep bits
00000000 00000005
00001000 00002000 00000040 00000080 0000000c 00000003 00000003 00000001 00000001 00000010
00000020 00000000 00000004 00000002 12340000 12348000 00000100 00000200 00000010 00000001
// Test 2: no-start mode
00000001 00000000
deadbeef cafef00d 01234567 89abcdef 76543210 fedcba98 0f0f0f0f f0f0f0f0 55555555 aaaaaaaa
33333333 cccccccc 00ff00ff ff00ff00 13579bdf 2468ace0 80000000 00000001 7fffffff fffffffe
// Test 3: run mode, all keep bits
0000000e 0000000c
a5000001 a5000002 a5000003 a5000004 a5000005 a5000006 a5000007 a5000008 a5000009 a500000a
a500000b a500000c a500000d a500000e a500000f a5000010 a5000011 a5000012 a5000013 a5000014
// Test 4: no-start mode, keep_a and keep_c
0000000b 00000003
00000000 ffffffff 00000000 ffffffff 10203040 50607080 90a0b0c0 d0e0f000 11111111 22222222
44444444 88888888 01010101 02020202 04040404 08080808 1a2b3c4d 5e6f7a8b 9cadbecf 00c0ffee
// Test 5: run mode, keep_b, immediate interrupt
00000004 00000000
3c000000 3c000400 3c000800 3c000c00 00000007 00000007 00000040 00000040 00000003 00000003
00000002 00000002 00000001 00000000 3d000000 3d001000 00000020 00000020 00000040 00000001
// Test 6: no-start mode, keep_a and keep_b
00000007 00000001
6b8b4567 327b23c6 643c9869 66334873 74b0dc51 19495cff 2ae8944a 625558ec 238e1f29 46e87ccd
3d1b58ba 507ed7ab 2eb141f2 41b71efb 79e2a9e3 7545e146 515f007c 5bd062c2 12200854 4db127f8

/* src.f */
logic/cfg_addr_pkg.sv
logic/seq_pkg.sv
logic/seq_fsm.sv
logic/wresp_tracker.sv
logic/cfg_write_gen.sv
logic/accel_cfg_sequencer.sv
tb/tb_clock.sv
tb/seq_assertions.sv
tb/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -f src.f --top-module tb_top \
        -Mdir "$BUILD_DIR" -o tb_top_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$BUILD_DIR/tb_top_sim" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi
cat "$LOG"

if ! grep -qx "Test OK" "$LOG"; then
    echo "Pass message not found in $LOG"
    exit 1
fi
exit 0
